//--- project.f
design/hzrd_pkg.sv
design/riscv_hzrd_if.sv
design/riscv_instdecoder.sv
design/riscv_stageregs.sv
design/riscv_muldiv_timer.sv
design/riscv_hazardunit.sv
design/riscv_hzrd_top.sv
dv/tb_riscv_hzrd.sv

//--- Makefile
# Verilator build and run for the hazard-control testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_hzrd
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF -- '$(PASS_MSG)' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_riscv_hzrd.sv
`timescale 1ns/1ps

module tb_riscv_hzrd;

  localparam int MULDIV_LATENCY = 4;
  localparam int WAIT_LIMIT     = 50;

  logic        i_clk;
  logic        i_rst;
  logic        i_instr_valid;
  logic [31:0] i_instr;
  logic        i_pcsrc;
  logic        i_dcache_stall;
  logic        o_instr_ready;
  logic [1:0]  o_fwda;
  logic [1:0]  o_fwdb;
  logic        o_stallpc;
  logic        o_stallde;
  logic        o_flushfd;
  logic        o_flushde;
  logic        o_passwb;

  logic [31:0] lcg_state;
  int          err_cnt;
  int          test_errs;
  int          timeouts;
  int          tests_run;

  riscv_hzrd_top #(.MULDIV_LATENCY (MULDIV_LATENCY)) dut (.*);

  always #2 i_clk = ~i_clk;  // 4 ns period

  ////////////////////////////////////////
  // Stimulus helpers
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Register 1..31 from the upper bits
  function automatic logic [4:0] pick_reg();
    logic [31:0] raw;
    raw = lcg_next();
    return 5'((raw[31:16] % 16'd31) + 16'd1);
  endfunction

  function automatic logic [31:0] add_instr(input logic [4:0] rd, rs1, rs2);
    return {7'd0, rs2, rs1, 3'd0, rd, hzrd_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] mul_instr(input logic [4:0] rd, rs1, rs2);
    return {7'd1, rs2, rs1, 3'd0, rd, hzrd_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] lw_instr(input logic [4:0] rd, rs1);
    return {12'd0, rs1, 3'b010, rd, hzrd_pkg::OPC_LOAD};
  endfunction

  function automatic logic [31:0] lui_instr(input logic [4:0] rd);
    return {20'habcde, rd, hzrd_pkg::OPC_LUI};
  endfunction

  // CSRRW on mscratch
  function automatic logic [31:0] csrrw_instr(input logic [4:0] rd, rs1);
    return {12'h340, rs1, 3'b001, rd, hzrd_pkg::OPC_SYSTEM};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED @ %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("%-16s done, %0d mismatches", name, test_errs);
    test_errs = 0;
  endtask

  // Drive at the falling edge and sample 1 ns later
  task automatic step(input logic v, input logic [31:0] w, input logic br, input logic ds);
    @(negedge i_clk);
    i_instr_valid  = v;
    i_instr        = w;
    i_pcsrc        = br;
    i_dcache_stall = ds;
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 32'd0, 1'b0, 1'b0);
  endtask

  // Hold the word until ready is seen
  task automatic push(input logic [31:0] w);
    int waited;
    waited = 0;
    step(1'b1, w, 1'b0, 1'b0);
    while (!o_instr_ready && waited < WAIT_LIMIT)
    begin
      waited++;
      step(1'b1, w, 1'b0, 1'b0);
    end
    if (!o_instr_ready)
    begin
      $display("Timeout: the DUT never accepted instruction word %08h", w);
      timeouts++;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  task automatic reset_state();
    idle(1);
    check("ready after reset", o_instr_ready, 1);
    check("stall/flush/passwb after reset",
          {o_stallpc, o_stallde, o_flushfd, o_flushde, o_passwb}, 0);
    check("forwarding after reset", {o_fwda, o_fwdb}, 0);
    report_test("reset");
  endtask

  // Instruction k of a burst sits in E k+2 cycles after the first push
  task automatic forward_paths(input logic [4:0] r, input logic [4:0] r2);
    idle(5);
    push(add_instr(r, 5'd0, 5'd0));
    push(add_instr(r2, r, 5'd0));
    push(add_instr(5'd0, 5'd0, r));
    idle(1);
    check("fwda from M", o_fwda, 2);
    idle(1);
    check("fwdb from W", o_fwdb, 1);
    idle(5);
    push(lui_instr(r));
    push(add_instr(r2, r, 5'd0));
    idle(2);
    check("fwda from LUI in M", o_fwda, 3);
    idle(5);
    push(add_instr(5'd0, r, r));
    push(add_instr(r2, 5'd0, 5'd0));
    idle(2);
    check("fwda for x0", o_fwda, 0);
    report_test("forwarding");
  endtask

  task automatic load_use_stall(input logic [4:0] r, input logic [4:0] r2);
    idle(5);
    push(lw_instr(r, 5'd0));
    push(add_instr(r2, r, 5'd0));
    idle(1);  // LW in E, reader in D
    check("load-use stallpc", o_stallpc, 1);
    check("load-use flushde", o_flushde, 1);
    check("load-use ready", o_instr_ready, 0);
    idle(1);
    check("stallpc one cycle later", o_stallpc, 0);
    check("ready one cycle later", o_instr_ready, 1);
    idle(1);  // Load has reached W by now
    check("fwda after load-use", o_fwda, 1);
    report_test("load_use");
  endtask

  task automatic branch_flush(input logic [4:0] r, input logic [4:0] r2);
    idle(5);
    push(add_instr(r, 5'd0, 5'd0));
    step(1'b1, add_instr(r2, 5'd0, 5'd0), 1'b1, 1'b0);
    check("flushfd on pcsrc", o_flushfd, 1);
    check("flushde on pcsrc", o_flushde, 1);
    check("ready during flush", o_instr_ready, 1);
    push(add_instr(5'd0, r, r2));
    idle(2);
    check("fwd from flushed stages", {o_fwda, o_fwdb}, 0);
    report_test("branch_flush");
  endtask

  task automatic muldiv_stall(input logic [4:0] r);
    int n;
    n = 0;
    idle(5);
    push(mul_instr(r, 5'd0, 5'd0));
    idle(1);
    step(1'b0, 32'd0, 1'b1, 1'b0);  // MUL in E, branch held
    while (o_stallde && n < WAIT_LIMIT)
    begin
      n++;
      check("flush under mul/div stall", {o_flushfd, o_flushde}, 0);
      step(1'b0, 32'd0, 1'b1, 1'b0);
    end
    if (o_stallde)
    begin
      $display("Timeout: mul/div stall never released");
      timeouts++;
    end
    check("mul/div stall cycles", n, MULDIV_LATENCY - 1);
    idle(1);
    report_test("muldiv");
  endtask

  task automatic dcache_stall(input logic [4:0] r, input logic [4:0] r2);
    int len;
    len = 2 + int'(lcg_next() >> 29);
    idle(5);
    push(add_instr(r, 5'd0, 5'd0));
    push(add_instr(r2, r, 5'd0));
    repeat (len)  // Writer in E, reader in D
    begin
      step(1'b0, 32'd0, 1'b1, 1'b1);  // Branch held as well
      check("stallde under dcache stall", o_stallde, 1);
      check("flush or ready under dcache stall", {o_flushfd, o_flushde, o_instr_ready}, 0);
    end
    idle(1);
    check("stallde after release", o_stallde, 0);
    idle(1);
    check("fwda after dcache stall", o_fwda, 2);
    report_test("dcache");
  endtask

  task automatic csr_passthrough(input logic [4:0] r, input logic [4:0] r2);
    idle(5);
    push(csrrw_instr(r, 5'd0));
    push(csrrw_instr(r2, r));
    idle(3);  // First CSR in W, second in M
    check("passwb on rd match", o_passwb, 1);
    idle(5);
    push(csrrw_instr(r, 5'd0));
    push(csrrw_instr(r2, r2));
    idle(3);
    check("passwb on rd mismatch", o_passwb, 0);
    report_test("csr_pass");
  endtask

  initial
  begin
    logic [4:0] ra;
    logic [4:0] rb;
    i_clk          = 1'b0;
    i_rst          = 1'b1;
    i_instr_valid  = 1'b0;
    i_instr        = 32'd0;
    i_pcsrc        = 1'b0;
    i_dcache_stall = 1'b0;
    lcg_state      = 32'h00c2dec2;
    err_cnt        = 0;
    test_errs      = 0;
    timeouts       = 0;
    tests_run      = 0;
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    ra = pick_reg();
    rb = 5'((ra % 5'd31) + 5'd1);  // Always differs from ra
    reset_state();
    forward_paths(ra, rb);
    load_use_stall(ra, rb);
    branch_flush(ra, rb);
    muldiv_stall(ra);
    dcache_stall(ra, rb);
    csr_passthrough(ra, rb);

    $display("Tests: %0d, mismatches: %0d, timeouts: %0d", tests_run, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- design/riscv_hzrd_top.sv
`timescale 1ns/1ps

module riscv_hzrd_top #(
  parameter int MULDIV_LATENCY = 4
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_instr_valid,
  input  logic [31:0] i_instr,
  input  logic        i_pcsrc,
  input  logic        i_dcache_stall,
  output logic        o_instr_ready,
  output logic [1:0]  o_fwda,
  output logic [1:0]  o_fwdb,
  output logic        o_stallpc,
  output logic        o_stallde,
  output logic        o_flushfd,
  output logic        o_flushde,
  output logic        o_passwb
);

  hzrd_pkg::stage_desc_t desc_f;  // Decoded word at the F/D input
  logic                  stallfd;
  logic                  stallem;
  logic                  stallmw;
  logic                  muldiv_valid;

  riscv_hzrd_if hzrd_if ();

  assign o_instr_ready = !stallfd;  // Flush still takes the word

  riscv_instdecoder u_decoder (
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_desc        (desc_f)
  );

  riscv_stageregs u_stageregs (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_desc    (desc_f),
    .i_stallfd (stallfd),
    .i_stallde (o_stallde),
    .i_stallem (stallem),
    .i_stallmw (stallmw),
    .i_flushfd (o_flushfd),
    .i_flushde (o_flushde),
    .o_stages  (hzrd_if.stages)
  );

  riscv_muldiv_timer #(
    .MULDIV_LATENCY (MULDIV_LATENCY)
  ) u_muldiv_timer (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_muldiv_e (hzrd_if.desc_e.is_muldiv),
    .o_valid    (muldiv_valid)
  );

  riscv_hazardunit u_hazardunit (
    .i_stages       (hzrd_if.hazard),
    .i_pcsrc        (i_pcsrc),
    .i_dcache_stall (i_dcache_stall),
    .i_muldiv_valid (muldiv_valid),
    .o_fwda         (o_fwda),
    .o_fwdb         (o_fwdb),
    .o_stallpc      (o_stallpc),
    .o_stallfd      (stallfd),
    .o_stallde      (o_stallde),
    .o_stallem      (stallem),
    .o_stallmw      (stallmw),
    .o_flushfd      (o_flushfd),
    .o_flushde      (o_flushde),
    .o_passwb       (o_passwb)
  );

endmodule

//--- design/riscv_hazardunit.sv
`timescale 1ns/1ps

module riscv_hazardunit (
  riscv_hzrd_if.hazard i_stages,
  input  logic         i_pcsrc,
  input  logic         i_dcache_stall,
  input  logic         i_muldiv_valid,
  output logic [1:0]   o_fwda,
  output logic [1:0]   o_fwdb,
  output logic         o_stallpc,
  output logic         o_stallfd,
  output logic         o_stallde,
  output logic         o_stallem,
  output logic         o_stallmw,
  output logic         o_flushfd,
  output logic         o_flushde,
  output logic         o_passwb
);

  logic glob_stall;
  logic lu_rs1;
  logic lu_rs2;
  logic e_late;     // E result not ready for D next cycle
  logic load_use;
  logic branch_flush;

  // Select for one E source operand
  function automatic logic [1:0] fwd_sel(
    input logic [4:0]            src,
    input hzrd_pkg::stage_desc_t m,
    input hzrd_pkg::stage_desc_t w
  );
    logic m_hit;
    logic w_hit;
    m_hit = m.valid && m.regw && (m.rd != 5'd0) && (m.rd == src);
    w_hit = w.valid && w.regw && (w.rd != 5'd0) && (w.rd == src);
    if (m_hit && (m.opcode == hzrd_pkg::OPC_LUI))
      return hzrd_pkg::FWD_MEM_UIMM;
    else if (m_hit)
      return hzrd_pkg::FWD_MEM;
    else if (w_hit)
      return hzrd_pkg::FWD_WB;
    else
      return hzrd_pkg::FWD_NONE;
  endfunction

  ////////////////////////////////////////
  // Forwarding
  assign o_fwda = fwd_sel(i_stages.desc_e.rs1, i_stages.desc_m, i_stages.desc_w);
  assign o_fwdb = fwd_sel(i_stages.desc_e.rs2, i_stages.desc_m, i_stages.desc_w);

  ////////////////////////////////////////
  // Stalls
  assign glob_stall = i_dcache_stall || (i_stages.desc_e.is_muldiv && !i_muldiv_valid);

  assign lu_rs1 = (i_stages.desc_d.rs1 == i_stages.desc_e.rd);
  assign lu_rs2 = i_stages.desc_d.uses_rs2 && !i_stages.desc_d.is_csr &&
                  (i_stages.desc_d.rs2 == i_stages.desc_e.rd);

  // CSR read in E is late unless D is a CSR too
  assign e_late = (i_stages.desc_e.resultsrc == hzrd_pkg::RESULT_LOAD) ||
                  (i_stages.desc_e.is_csr && !i_stages.desc_d.is_csr);

  assign load_use = i_stages.desc_d.valid && (i_stages.desc_e.rd != 5'd0) &&
                    (lu_rs1 || lu_rs2) && e_late;

  assign branch_flush = i_pcsrc && !glob_stall;

  // A taken branch kills D, so no need to hold it
  assign o_stallfd = (load_use && !branch_flush) || glob_stall;
  assign o_stallpc = o_stallfd;
  assign o_stallde = glob_stall;
  assign o_stallem = glob_stall;
  assign o_stallmw = glob_stall;

  ////////////////////////////////////////
  // Flushes
  assign o_flushfd = branch_flush;
  assign o_flushde = (load_use || i_pcsrc) && !glob_stall;  // Bubble into E

  // CSR in W feeding a CSR in M
  assign o_passwb = i_stages.desc_m.is_csr && i_stages.desc_w.is_csr &&
                    (i_stages.desc_w.rd == i_stages.desc_m.rs1);

  always_comb
  begin
    a_flush_under_stall: assert final (!(o_flushfd && glob_stall));
  end

endmodule

//--- design/riscv_muldiv_timer.sv
`timescale 1ns/1ps

module riscv_muldiv_timer #(
  parameter int MULDIV_LATENCY = 4
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_muldiv_e,
  output logic o_valid
);

  localparam int CW = $clog2(MULDIV_LATENCY);

  logic [CW-1:0] count;

  assign o_valid = i_muldiv_e && (count == CW'(MULDIV_LATENCY - 1));

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      count <= '0;
    end
    else if (o_valid || !i_muldiv_e)
    begin
      count <= '0;  // Ready for the next op
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // An op still waiting for valid stays in E
  a_op_held: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_muldiv_e && !o_valid) |=> i_muldiv_e);

endmodule

//--- design/riscv_stageregs.sv
`timescale 1ns/1ps

module riscv_stageregs (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  hzrd_pkg::stage_desc_t i_desc,
  input  logic                  i_stallfd,
  input  logic                  i_stallde,
  input  logic                  i_stallem,
  input  logic                  i_stallmw,
  input  logic                  i_flushfd,
  input  logic                  i_flushde,
  riscv_hzrd_if.stages          o_stages
);

  localparam hzrd_pkg::stage_desc_t BUBBLE = '0;  // valid and regw low

  ////////////////////////////////////////
  // F/D
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_stages.desc_d <= BUBBLE;
    end
    else if (i_flushfd)
    begin
      o_stages.desc_d <= BUBBLE;  // Offered word is dropped
    end
    else if (!i_stallfd)
    begin
      o_stages.desc_d <= i_desc;
    end
  end

  ////////////////////////////////////////
  // D/E
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_stages.desc_e <= BUBBLE;
    end
    else if (!i_stallde)
    begin
      // Load-use hold of D also lets a bubble into E
      if (i_flushde || i_stallfd)
        o_stages.desc_e <= BUBBLE;
      else
        o_stages.desc_e <= o_stages.desc_d;
    end
  end

  ////////////////////////////////////////
  // E/M and M/W
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_stages.desc_m <= BUBBLE;
    end
    else if (!i_stallem)
    begin
      o_stages.desc_m <= o_stages.desc_e;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_stages.desc_w <= BUBBLE;
    end
    else if (!i_stallmw)
    begin
      o_stages.desc_w <= o_stages.desc_m;
    end
  end

  // D must not move while held
  a_d_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_stallfd |=> $stable(o_stages.desc_d));

  a_no_stall_flush: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_stallfd && i_flushfd) && !(i_stallde && i_flushde));

endmodule

//--- design/riscv_instdecoder.sv
`timescale 1ns/1ps

module riscv_instdecoder (
  input  logic                  i_instr_valid,
  input  hzrd_pkg::instr_word_u i_instr,
  output hzrd_pkg::stage_desc_t o_desc
);

  logic [6:0] opcode;

  assign opcode = i_instr.r.opcode;  // Same bits in every view

  always_comb
  begin
    o_desc = '0;  // Bubble unless a word is offered
    if (i_instr_valid)
    begin
      o_desc.valid  = 1'b1;
      o_desc.opcode = opcode;
      case (opcode)
        hzrd_pkg::OPC_OP:
        begin
          o_desc.rs1       = i_instr.r.rs1;
          o_desc.rs2       = i_instr.r.rs2;
          o_desc.rd        = i_instr.r.rd;
          o_desc.regw      = (i_instr.r.rd != 5'd0);
          o_desc.uses_rs2  = 1'b1;
          o_desc.is_muldiv = (i_instr.r.funct7 == 7'b0000001);  // M extension
        end
        hzrd_pkg::OPC_OPIMM:
        begin
          o_desc.rs1  = i_instr.i.rs1;
          o_desc.rd   = i_instr.i.rd;
          o_desc.regw = (i_instr.i.rd != 5'd0);
        end
        hzrd_pkg::OPC_LOAD:
        begin
          o_desc.rs1       = i_instr.i.rs1;
          o_desc.rd        = i_instr.i.rd;
          o_desc.regw      = (i_instr.i.rd != 5'd0);
          o_desc.resultsrc = hzrd_pkg::RESULT_LOAD;
        end
        hzrd_pkg::OPC_STORE:
        begin
          o_desc.rs1      = i_instr.s.rs1;
          o_desc.rs2      = i_instr.s.rs2;
          o_desc.uses_rs2 = 1'b1;  // No rd for stores
        end
        hzrd_pkg::OPC_LUI:
        begin
          o_desc.rd   = i_instr.u.rd;
          o_desc.regw = (i_instr.u.rd != 5'd0);
        end
        hzrd_pkg::OPC_SYSTEM:
        begin
          // funct3 of zero is ecall/ebreak, nothing to track
          if (i_instr.i.funct3 != 3'd0)
          begin
            o_desc.is_csr = 1'b1;
            o_desc.rs1    = i_instr.i.rs1;
            o_desc.rd     = i_instr.i.rd;
            o_desc.regw   = (i_instr.i.rd != 5'd0);
          end
        end
        default:
        begin
          o_desc.regw = 1'b0;  // Unknown opcode writes nothing
        end
      endcase
    end
  end

  // x0 is never a destination
  always_comb
  begin
    a_no_x0_write: assert final (!(o_desc.regw && (o_desc.rd == 5'd0)));
  end

endmodule

//--- design/riscv_hzrd_if.sv
`timescale 1ns/1ps

interface riscv_hzrd_if;

  hzrd_pkg::stage_desc_t desc_d;  // Decode
  hzrd_pkg::stage_desc_t desc_e;  // Execute
  hzrd_pkg::stage_desc_t desc_m;  // Memory
  hzrd_pkg::stage_desc_t desc_w;  // Writeback

  // Stage registers own the descriptors
  modport stages (
    output desc_d,
    output desc_e,
    output desc_m,
    output desc_w
  );

  // Hazard unit only looks
  modport hazard (
    input desc_d,
    input desc_e,
    input desc_m,
    input desc_w
  );

endinterface

//--- design/hzrd_pkg.sv
package hzrd_pkg;

  ////////////////////////////////////////
  // Opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [1:0] RESULT_LOAD = 2'b10;  // Result comes from memory

  ////////////////////////////////////////
  // Forwarding mux selects
  localparam logic [1:0] FWD_NONE     = 2'd0;
  localparam logic [1:0] FWD_WB       = 2'd1;
  localparam logic [1:0] FWD_MEM      = 2'd2;
  localparam logic [1:0] FWD_MEM_UIMM = 2'd3;  // Upper immediate out of M

  // One instruction word, four encodings
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] immhi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immlo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } instr_word_u;

  // What the hazard logic needs to know about one stage
  typedef struct packed {
    logic       valid;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [6:0] opcode;
    logic       regw;
    logic [1:0] resultsrc;
    logic       is_csr;
    logic       uses_rs2;
    logic       is_muldiv;
  } stage_desc_t;

endpackage
